// File: sources.f
+incdir+common
common/erx_pkg.sv
erx/erx_cfg.sv
erx/erx_remap.sv
hdl/erx_core.sv
verif/erx_tb.sv

// File: run_sim.sh
#!/bin/bash
# build the erx testbench with Verilator and run it
# the run counts as passed only if the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   -f sources.f \
   --top-module erx_tb \
   -o erx_sim \
   && ./obj_dir/erx_sim | tee /dev/stderr | grep -qx "Testbench passed" \
   && { echo "simulation result: pass"; exit 0; } \
   || { echo "simulation result: fail"; exit 1; }

// File: verif/erx_tb.sv
`timescale 1ns/10ps

`include "erx_config.svh"

module erx_tb
   import erx_pkg::*;
();

   localparam int          n_pkts  = 600;        // packets taken before the drain
   localparam int          pw      = `ERX_PW;
   localparam logic [11:0] link_id = `ERX_ID;

   logic          clk;
   logic          reset;
   logic          access_in;
   logic          wait_in;
   logic [pw-1:0] packet_in;
   logic          access_out;
   logic [pw-1:0] packet_out;

   // reference copy of the remap registers
   erx_remap_mode_t m_mode;
   logic [11:0]     m_sel;
   logic [11:0]     m_pattern;
   logic [31:0]     m_base;

   logic [pw-1:0] exp_q[$];    // packets taken, not yet seen at the output
   logic          prev_access;
   logic [pw-1:0] prev_packet;
   logic [31:0]   lfsr;
   int            taken;
   int            checks;
   int            value_errors;
   int            seq_errors;

   erx_core dut0
   (
      .clk        (clk),
      .reset      (reset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .access_out (access_out),
      .packet_out (packet_out)
   );

   always #4 clk = ~clk;

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   // column is a power of two, so the top set bit is its log2
   function automatic int col_log2(input logic [5:0] c);
      int n;
      n = 0;
      for (int i = 0; i < 6; i++)
         if (c[i])
            n = i;
      return n;
   endfunction

   function automatic logic is_cfg_write(input logic [pw-1:0] pkt);
      logic [19:0] off;
      off = pkt[27:8];
      return pkt[0] && (pkt[39:28] == link_id) &&
             (off >= `ERX_CFG_OFFSET) && (off <= `ERX_CFG_OFFSET + 20'd15);
   endfunction

   function automatic logic [31:0] remap_addr(input logic [31:0] a, input logic wr);
      logic [31:0] r;
      r = a;
      if (wr && m_mode == remap_static)
      begin
         for (int i = 0; i < 12; i++)
            r[20 + i] = m_sel[i] ? m_pattern[i] : a[20 + i];
      end
      else if (wr && m_mode != remap_none)
      begin
         // spare code lands here too
         r = a - ({26'd0, link_id[5:0]} << 20) + m_base -
             ({26'd0, a[31:26]} << col_log2(link_id[5:0]));
      end
      return r;
   endfunction

   task automatic apply_cfg(input logic [pw-1:0] pkt);
      logic [31:0] data;
      logic [19:0] word;
      data = pkt[71:40];
      word = pkt[27:8] - `ERX_CFG_OFFSET;
      case (word[3:0])
         `ERX_REG_MODE:
            m_mode = erx_remap_mode_t'(data[1:0]);
         `ERX_REG_SELPAT:
         begin
            m_sel     = data[11:0];
            m_pattern = data[27:16];
         end
         `ERX_REG_BASE:
            m_base = data;
         default:
            ;  // unused word, nothing changes
      endcase
   endtask

   task automatic compare_value(input logic [pw-1:0] actual, input logic [pw-1:0] expected,
                                input string what);
      checks++;
      if (actual !== expected)
      begin
         value_errors++;
         $display("Fail at %0t: %s, got %h expected %h", $time, what, actual, expected);
      end
   endtask

   task automatic make_packet(output logic [pw-1:0] pkt);
      logic [31:0] r;
      logic [31:0] dst;
      logic [31:0] data;
      logic [31:0] src;
      logic [7:0]  low;
      logic [3:0]  word;
      rand_bits(32, data);
      rand_bits(32, src);
      rand_bits(8, r);
      low = r[7:0];
      rand_bits(3, r);
      if (r[2:0] == 3'd0)
      begin
         rand_bits(6, r);
         if (r[1:0] == 2'd3)
            word = r[5:2];            // mostly unused words
         else
            word = {r[1:0], 2'b00};   // mode, select/pattern or base
         dst = {link_id, `ERX_CFG_OFFSET + {16'd0, word}};
         rand_bits(2, r);
         low[0] = (r[1:0] != 2'd0);   // some reads into the window
      end
      else
         rand_bits(32, dst);
      pkt = {src, data, dst, low};
   endtask

   // looks at the edge just past; inputs were held across it
   task automatic observe_edge();
      logic [pw-1:0] exp_pkt;
      if (access_in && !wait_in)
      begin
         taken++;
         if (is_cfg_write(packet_in))
            apply_cfg(packet_in);
         else
         begin
            exp_pkt        = packet_in;
            exp_pkt[39:8]  = remap_addr(packet_in[39:8], packet_in[0]);
            exp_q.push_back(exp_pkt);
         end
      end
      if (wait_in)
      begin
         compare_value(pw'(access_out), pw'(prev_access), "access_out moved during wait");
         compare_value(packet_out, prev_packet, "packet_out moved during wait");
      end
      else if (access_out)
      begin
         if (exp_q.size() == 0)
         begin
            $display("Output packet at %0t when no packet was expected", $time);
            seq_errors++;
         end
         else
            compare_value(packet_out, exp_q.pop_front(), "packet_out");
      end
      else if (exp_q.size() != 0)
      begin
         $display("Packet lost at %0t, access_out stayed low", $time);
         seq_errors++;
         exp_q.delete();
      end
      prev_access = access_out;
      prev_packet = packet_out;
   endtask

   task automatic drive_next();
      logic [31:0]   r;
      logic [pw-1:0] pkt;
      if (!(access_in && wait_in))   // a stalled packet stays put
      begin
         rand_bits(2, r);
         if (r[1:0] != 2'd0 && taken < n_pkts)
         begin
            make_packet(pkt);
            packet_in = pkt;
            access_in = 1'b1;
         end
         else
            access_in = 1'b0;
      end
      rand_bits(2, r);
      wait_in = (r[1:0] == 2'd0);
   endtask

   initial
   begin
      clk          = 1'b0;
      reset        = 1'b1;
      access_in    = 1'b0;
      wait_in      = 1'b0;
      packet_in    = '0;
      m_mode       = remap_none;
      m_sel        = '0;
      m_pattern    = '0;
      m_base       = '0;
      lfsr         = 32'h5e2;
      taken        = 0;
      checks       = 0;
      value_errors = 0;
      seq_errors   = 0;
      repeat (10) @(negedge clk);
      reset       = 1'b0;
      prev_access = access_out;
      prev_packet = packet_out;
      while (taken < n_pkts)
      begin
         @(negedge clk);
         observe_edge();
         drive_next();
      end
      access_in = 1'b0;   // drain the last packet
      wait_in   = 1'b0;
      repeat (3)
      begin
         @(negedge clk);
         observe_edge();
      end
      if (exp_q.size() != 0)
      begin
         $display("%0d packets never reached the output", exp_q.size());
         seq_errors += exp_q.size();
      end
      $display("checks %0d, value errors %0d, sequence errors %0d",
               checks, value_errors, seq_errors);
      if (value_errors + seq_errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

   // worst case of four cycles per packet plus margin
   initial
   begin
      #(8 * n_pkts * 4 + 2000);
      $display("Watchdog expired at %0t, the run did not finish in time", $time);
      $display("Testbench failed");
      $finish;
   end

endmodule

// File: hdl/erx_core.sv
`timescale 1ns/10ps

`include "erx_config.svh"

module erx_core
   import erx_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic              access_in,
   input  logic [`ERX_PW-1:0] packet_in,
   input  logic              wait_in,
   output logic              access_out,
   output logic [`ERX_PW-1:0] packet_out
);

   // cfg to remap
   logic              fwd_access;
   logic [`ERX_PW-1:0] fwd_packet;
   erx_remap_mode_t   remap_mode;
   logic [11:0]       remap_sel;
   logic [11:0]       remap_pattern;
   logic [31:0]       remap_base;

   // window decode and remap registers
   erx_cfg cfg0
   (
      .clk           (clk),
      .reset         (reset),
      .access_in     (access_in),
      .packet_in     (packet_in),
      .wait_in       (wait_in),
      .fwd_access    (fwd_access),
      .fwd_packet    (fwd_packet),
      .remap_mode    (remap_mode),
      .remap_sel     (remap_sel),
      .remap_pattern (remap_pattern),
      .remap_base    (remap_base)
   );

   // address rewrite and output register
   erx_remap remap0
   (
      .clk           (clk),
      .reset         (reset),
      .wait_in       (wait_in),
      .fwd_access    (fwd_access),
      .fwd_packet    (fwd_packet),
      .remap_mode    (remap_mode),
      .remap_sel     (remap_sel),
      .remap_pattern (remap_pattern),
      .remap_base    (remap_base),
      .access_out    (access_out),
      .packet_out    (packet_out)
   );

endmodule

// File: erx/erx_remap.sv
`timescale 1ns/10ps

`include "erx_config.svh"

module erx_remap
   import erx_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic              wait_in,
   input  logic              fwd_access,
   input  logic [`ERX_PW-1:0] fwd_packet,
   input  erx_remap_mode_t   remap_mode,
   input  logic [11:0]       remap_sel,
   input  logic [11:0]       remap_pattern,
   input  logic [31:0]       remap_base,
   output logic              access_out,
   output logic [`ERX_PW-1:0] packet_out
);

   // column of this link and its log2 for the row compression term
   localparam logic [5:0] col_id    = 6'(`ERX_ID);
   localparam int         col_shift = $clog2(col_id);

   erx_addr_t   addr_in;
   erx_addr_t   static_addr;
   logic [31:0] dynamic_addr;
   logic [31:0] col_term;
   logic [31:0] row_term;
   logic        remap_en;
   logic [31:0] remap_mux;

   assign addr_in.word = fwd_packet[39:8];

   // static map, per-bit replace of row/column
   assign static_addr.word[31:20] = (remap_sel & remap_pattern) |
                                    (~remap_sel & {addr_in.f.row, addr_in.f.col});
   assign static_addr.f.offset    = addr_in.f.offset;

   // compressed column map
   assign col_term     = 32'(col_id) << 20;            // start of this link's space
   assign row_term     = 32'(addr_in.f.row) << col_shift;
   assign dynamic_addr = addr_in.word - col_term + remap_base - row_term;

   // reads and mode none keep the address
   assign remap_en = (remap_mode != remap_none) & fwd_packet[0];

   always_comb
   begin
      if (!remap_en)
         remap_mux = addr_in.word;
      else if (remap_mode == remap_static)
         remap_mux = static_addr.word;
      else
         remap_mux = dynamic_addr;   // dynamic and the spare code
   end

   // output stage, frozen while downstream waits
   always_ff @(posedge clk)
   begin
      if (reset)
         access_out <= 1'b0;
      else if (!wait_in)
         access_out <= fwd_access;
   end

   always_ff @(posedge clk)
   begin
      if (!wait_in)
         packet_out <= {fwd_packet[`ERX_PW-1:40], remap_mux, fwd_packet[7:0]};
   end

   // downstream may sample late, so a stalled output must not move
   out_held_on_wait: assert property (
      @(posedge clk) disable iff (reset)
      wait_in |=> ($stable(access_out) && $stable(packet_out))
   );

endmodule

// File: erx/erx_cfg.sv
`timescale 1ns/10ps

`include "erx_config.svh"

module erx_cfg
   import erx_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic              access_in,
   input  logic [`ERX_PW-1:0] packet_in,
   input  logic              wait_in,
   output logic              fwd_access,
   output logic [`ERX_PW-1:0] fwd_packet,
   output erx_remap_mode_t   remap_mode,
   output logic [11:0]       remap_sel,
   output logic [11:0]       remap_pattern,
   output logic [31:0]       remap_base
);

   erx_addr_t   dst_addr;
   logic        write_flag;
   logic [31:0] data_word;
   logic        id_hit;
   logic [19:0] rel_offset;
   logic        in_window;
   logic [3:0]  reg_off;
   logic        cfg_write;

   // field extraction
   assign write_flag    = packet_in[0];
   assign dst_addr.word = packet_in[39:8];
   assign data_word     = packet_in[71:40];

   // window decode
   assign id_hit     = ({dst_addr.f.row, dst_addr.f.col} == `ERX_ID);
   assign rel_offset = dst_addr.f.offset - `ERX_CFG_OFFSET;
   assign in_window  = (rel_offset < 20'd16);  // wraps high when below the window
   assign reg_off    = rel_offset[3:0];

   // a stalled write counts only once it is taken
   assign cfg_write = access_in & ~wait_in & write_flag & id_hit & in_window;

   // configuration writes are consumed here
   assign fwd_access = access_in & ~cfg_write;
   assign fwd_packet = packet_in;

   // register file
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         remap_mode    <= remap_none;
         remap_sel     <= '0;
         remap_pattern <= '0;
         remap_base    <= '0;
      end
      else if (cfg_write)
      begin
         case (reg_off)
            `ERX_REG_MODE:
            begin
               remap_mode <= erx_remap_mode_t'(data_word[1:0]);
            end
            `ERX_REG_SELPAT:
            begin
               remap_sel     <= data_word[11:0];
               remap_pattern <= data_word[27:16];
            end
            `ERX_REG_BASE:
            begin
               remap_base <= data_word;
            end
            default:
            begin
               // write to an unused word is dropped
            end
         endcase
      end
   end

   // a window write taken by this stage must not reach the remap stage
   cfg_not_forwarded: assert property (
      @(posedge clk) disable iff (reset)
      (access_in && !wait_in && packet_in[0] &&
       (packet_in[39:28] == `ERX_ID) &&
       (packet_in[27:8] - `ERX_CFG_OFFSET < 20'd16))
      |-> !fwd_access
   );

endmodule

// File: common/erx_pkg.sv
package erx_pkg;

   // destination address of a mesh packet, bits 39:8
   // row and column together form the 12-bit link ID of the target
   typedef struct packed
   {
      logic [5:0]  row;    // mesh row
      logic [5:0]  col;    // mesh column
      logic [19:0] offset; // byte offset inside the link's 1 MB space
   } erx_addr_fields_t;

   // one address word, read either flat or by fields
   typedef union packed
   {
      logic [31:0]      word;  // flat view for arithmetic
      erx_addr_fields_t f;     // row/column/offset view
   } erx_addr_t;

   // remap mode register encoding
   // code 2'b11 is not named and takes the dynamic path
   typedef enum logic [1:0]
   {
      remap_none    = 2'b00, // address passes unchanged
      remap_static  = 2'b01, // upper 12 bits replaced under select mask
      remap_dynamic = 2'b10  // compressed column map
   } erx_remap_mode_t;

endpackage

// File: common/erx_config.svh
`ifndef ERX_CONFIG_SVH
`define ERX_CONFIG_SVH

// mesh packet width
// bit 0 write flag, 39:8 dst address, 71:40 data, 103:72 src address
`define ERX_PW 104

// link ID as {row, column}
// the low six bits give the column used by the dynamic map
`define ERX_ID 12'h808

// start of the configuration window inside the link's offset space
`define ERX_CFG_OFFSET 20'hF0300

// register word offsets inside the 16-byte window
`define ERX_REG_MODE   4'd0
`define ERX_REG_SELPAT 4'd4
`define ERX_REG_BASE   4'd8

`endif
